/* Makefile */
# store buffer simulation with Verilator

.PHONY: sim clean

sim:
	verilator --binary --timing -f src.f --top-module stbuf_tb -o stbuf_sim
	@out=$$(./obj_dir/stbuf_sim); echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

/* logic/stbuf_drain_fwd.sv */
module stbuf_drain_fwd (
   input  stbuf_pkg::stbuf_entry_t [stbuf_pkg::DEPTH-1:0] entries,
   input  logic [stbuf_pkg::PTR_W-1:0]                    rd_ptr,
   input  logic [stbuf_pkg::WADDR_W-1:0]                  ld_word_addr,
   output stbuf_pkg::stbuf_drain_t                        drain,
   output stbuf_pkg::ld_fwd_t                             fwd
);

   stbuf_pkg::stbuf_entry_t        head;
   logic [stbuf_pkg::DEPTH-1:0]    ld_hit;
   logic [stbuf_pkg::BYTE_W-1:0]   fwd_be;
   logic [stbuf_pkg::DATA_W-1:0]   fwd_data;

   // ------------------------------
   // drain side
   // ------------------------------
   assign head = entries[rd_ptr];

   always_comb begin
      drain.valid = head.valid;
      drain.waddr = head.waddr;
      drain.be    = head.be;
      drain.data  = head.data;
   end

   // ------------------------------
   // load forwarding
   // ------------------------------
   always_comb begin
      for (int i = 0; i < stbuf_pkg::DEPTH; i++) begin
         ld_hit[i] = entries[i].valid && (entries[i].waddr == ld_word_addr);
      end
   end

   // at most one live entry per word, so an OR merge is enough
   always_comb begin
      fwd_be   = '0;
      fwd_data = '0;
      for (int i = 0; i < stbuf_pkg::DEPTH; i++) begin
         if (ld_hit[i]) begin
            fwd_be = fwd_be | entries[i].be;
         end
         for (int b = 0; b < stbuf_pkg::BYTE_W; b++) begin
            if (ld_hit[i] && entries[i].be[b]) begin
               fwd_data[8*b +: 8] = fwd_data[8*b +: 8] | entries[i].data[8*b +: 8];
            end
         end
      end
   end

   always_comb begin
      fwd.be   = fwd_be;
      fwd.data = fwd_data;   // bytes without enable read as zero
   end

endmodule

/* logic/stbuf_pkg.sv */
package stbuf_pkg;

   // ------------------------------
   // sizes
   // ------------------------------
   localparam int DEPTH   = 4;              // store buffer entries
   localparam int ADDR_W  = 16;             // byte address
   localparam int DATA_W  = 32;
   localparam int BYTE_W  = 4;              // bytes per word
   localparam int OFS_W   = 2;              // byte offset within word
   localparam int WADDR_W = ADDR_W - OFS_W; // word address
   localparam int PTR_W   = 2;
   localparam int CNT_W   = 3;              // 0 .. DEPTH

   // access size of a store
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } store_size_e;

   // ------------------------------
   // packets
   // ------------------------------
   typedef struct packed {
      logic                valid;
      store_size_e         size;
      logic [ADDR_W-1:0]   addr;   // byte address, aligned to size
      logic [DATA_W-1:0]   data;   // right aligned
   } store_req_t;

   // store placed in its lanes
   typedef struct packed {
      logic                valid;
      logic [WADDR_W-1:0]  waddr;
      logic [BYTE_W-1:0]   be;
      logic [DATA_W-1:0]   data;
   } lane_wr_t;

   typedef struct packed {
      logic                valid;
      logic [WADDR_W-1:0]  waddr;
      logic [BYTE_W-1:0]   be;
      logic [DATA_W-1:0]   data;
   } stbuf_entry_t;

   typedef struct packed {
      logic                valid;
      logic [WADDR_W-1:0]  waddr;
      logic [BYTE_W-1:0]   be;
      logic [DATA_W-1:0]   data;
   } stbuf_drain_t;

   typedef struct packed {
      logic [BYTE_W-1:0]   be;     // bytes the buffer holds
      logic [DATA_W-1:0]   data;
   } ld_fwd_t;

endpackage

/* logic/stbuf_queue.sv */
module stbuf_queue (
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   input  stbuf_pkg::lane_wr_t                                  wr,
   input  logic                                                 commit,
   output stbuf_pkg::stbuf_entry_t [stbuf_pkg::DEPTH-1:0]       entries,
   output logic [stbuf_pkg::PTR_W-1:0]                          rd_ptr,
   output logic                                                 full,
   output logic                                                 empty
);

   // control state
   logic [stbuf_pkg::DEPTH-1:0]   vld_q;
   logic [stbuf_pkg::PTR_W-1:0]   wr_ptr_q;
   logic [stbuf_pkg::PTR_W-1:0]   rd_ptr_q;
   logic [stbuf_pkg::CNT_W-1:0]   count_q;

   // payload
   logic [stbuf_pkg::WADDR_W-1:0] waddr_q [stbuf_pkg::DEPTH];
   logic [stbuf_pkg::BYTE_W-1:0]  be_q    [stbuf_pkg::DEPTH];
   logic [stbuf_pkg::DATA_W-1:0]  data_q  [stbuf_pkg::DEPTH];

   logic [stbuf_pkg::DEPTH-1:0]   popping;
   logic [stbuf_pkg::DEPTH-1:0]   match;
   logic [stbuf_pkg::DEPTH-1:0]   alloc_sel;
   logic [stbuf_pkg::DATA_W-1:0]  merged  [stbuf_pkg::DEPTH];
   logic                          pop;
   logic                          hit;
   logic                          alloc;

   assign pop = commit && vld_q[rd_ptr_q];  // only a live head pops

   // ------------------------------
   // coalesce lookup
   // ------------------------------
   always_comb begin
      for (int i = 0; i < stbuf_pkg::DEPTH; i++) begin
         popping[i]   = pop && (rd_ptr_q == stbuf_pkg::PTR_W'(i));
         // never merge into the entry leaving this cycle
         match[i]     = vld_q[i] && !popping[i] && (waddr_q[i] == wr.waddr);
         alloc_sel[i] = (wr_ptr_q == stbuf_pkg::PTR_W'(i));
      end
   end

   assign hit   = |match;
   assign alloc = wr.valid && !hit;

   // newer bytes win, the rest stay
   always_comb begin
      for (int i = 0; i < stbuf_pkg::DEPTH; i++) begin
         for (int b = 0; b < stbuf_pkg::BYTE_W; b++) begin
            merged[i][8*b +: 8] = wr.be[b] ? wr.data[8*b +: 8] : data_q[i][8*b +: 8];
         end
      end
   end

   // ------------------------------
   // pointers, valids, count
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_q    <= '0;
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (pop) begin
            vld_q[rd_ptr_q] <= 1'b0;
            rd_ptr_q        <= rd_ptr_q + stbuf_pkg::PTR_W'(1);
         end
         if (alloc) begin
            vld_q[wr_ptr_q] <= 1'b1;               // set after clear, alloc wins
            wr_ptr_q        <= wr_ptr_q + stbuf_pkg::PTR_W'(1);
         end
         count_q <= count_q + stbuf_pkg::CNT_W'(alloc) - stbuf_pkg::CNT_W'(pop);
      end
   end

   // ------------------------------
   // entry payload
   // ------------------------------
   always_ff @(posedge clk) begin
      for (int i = 0; i < stbuf_pkg::DEPTH; i++) begin
         if (alloc && alloc_sel[i]) begin
            waddr_q[i] <= wr.waddr;
            be_q[i]    <= wr.be;
            data_q[i]  <= wr.data;
         end else if (wr.valid && match[i]) begin
            be_q[i]    <= be_q[i] | wr.be;   // coalesce
            data_q[i]  <= merged[i];
         end
      end
   end

   // ------------------------------
   // outputs
   // ------------------------------
   always_comb begin
      for (int i = 0; i < stbuf_pkg::DEPTH; i++) begin
         entries[i].valid = vld_q[i];
         entries[i].waddr = waddr_q[i];
         entries[i].be    = be_q[i];
         entries[i].data  = data_q[i];
      end
   end

   assign rd_ptr = rd_ptr_q;
   assign full   = (count_q == stbuf_pkg::CNT_W'(stbuf_pkg::DEPTH));
   assign empty  = (count_q == '0);

endmodule

/* logic/stbuf_top.sv */
module stbuf_top (
   input  logic                                clk,
   input  logic                                rst_n,
   input  stbuf_pkg::store_req_t               store,
   input  logic                                commit,       // pops head
   input  logic [stbuf_pkg::WADDR_W-1:0]       ld_word_addr, // lookup level
   output stbuf_pkg::stbuf_drain_t             drain,
   output stbuf_pkg::ld_fwd_t                  fwd,
   output logic                                full,
   output logic                                empty
);

   stbuf_pkg::lane_wr_t                            lane_wr;
   stbuf_pkg::stbuf_entry_t [stbuf_pkg::DEPTH-1:0] entries;
   logic [stbuf_pkg::PTR_W-1:0]                    rd_ptr;

   // ------------------------------
   // store -> lanes -> buffer -> drain/fwd
   // ------------------------------
   store_lane_align u_align (
      .req (store),
      .wr  (lane_wr)
   );

   stbuf_queue u_queue (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr      (lane_wr),
      .commit  (commit),
      .entries (entries),
      .rd_ptr  (rd_ptr),
      .full    (full),
      .empty   (empty)
   );

   stbuf_drain_fwd u_drain_fwd (
      .entries      (entries),
      .rd_ptr       (rd_ptr),
      .ld_word_addr (ld_word_addr),
      .drain        (drain),
      .fwd          (fwd)
   );

endmodule

/* logic/store_lane_align.sv */
module store_lane_align (
   input  stbuf_pkg::store_req_t req,
   output stbuf_pkg::lane_wr_t   wr
);

   logic [stbuf_pkg::OFS_W-1:0]  ofs;
   logic [stbuf_pkg::BYTE_W-1:0] size_mask;
   logic [stbuf_pkg::BYTE_W-1:0] lane_be;
   logic [stbuf_pkg::DATA_W-1:0] lane_data;
   logic [stbuf_pkg::DATA_W-1:0] be_bits;

   assign ofs = req.addr[stbuf_pkg::OFS_W-1:0];

   // ------------------------------
   // size decode
   // ------------------------------
   always_comb begin
      case (req.size)
         stbuf_pkg::SZ_BYTE: size_mask = 4'b0001;
         stbuf_pkg::SZ_HALF: size_mask = 4'b0011;
         stbuf_pkg::SZ_WORD: size_mask = 4'b1111;
         default:            size_mask = 4'b0000;  // unused encoding
      endcase
   end

   // shift into lanes, anything past byte 3 falls off
   assign lane_be   = size_mask << ofs;
   assign lane_data = req.data << {ofs, 3'b000};

   // expand enables to a bit mask
   always_comb begin
      for (int b = 0; b < stbuf_pkg::BYTE_W; b++) begin
         be_bits[8*b +: 8] = {8{lane_be[b]}};
      end
   end

   // keep unused lanes at zero so a fresh entry carries no stale bytes
   always_comb begin
      wr.valid = req.valid;
      wr.waddr = req.addr[stbuf_pkg::ADDR_W-1:stbuf_pkg::OFS_W];
      wr.be    = lane_be;
      wr.data  = lane_data & be_bits;
   end

endmodule

/* src.f */
+incdir+tb
logic/stbuf_pkg.sv
logic/store_lane_align.sv
logic/stbuf_queue.sv
logic/stbuf_drain_fwd.sv
logic/stbuf_top.sv
tb/stbuf_tb.sv

/* tb/stbuf_checks.svh */
`ifndef STBUF_CHECKS_SVH
`define STBUF_CHECKS_SVH

// ------------------------------
// failure and compare tasks
// ------------------------------

// print the reason, then stop the run
task automatic abort_run(input string msg);
   $display("%s", msg);
   $display("Verification failed");
   $fatal(1);
endtask

// payload of an invalid head is don't care
task automatic check_drain(input string name,
                           input stbuf_pkg::stbuf_drain_t got,
                           input stbuf_pkg::stbuf_drain_t exp);
   if ((got.valid !== exp.valid) || (exp.valid && (got !== exp))) begin
      abort_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
   end
endtask

task automatic check_fwd(input string name,
                         input stbuf_pkg::ld_fwd_t got,
                         input stbuf_pkg::ld_fwd_t exp);
   if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
   end
endtask

task automatic check_flag(input string name,
                          input logic got,
                          input logic exp);
   if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
   end
endtask

`endif

/* tb/stbuf_tb.sv */
module stbuf_tb;

   typedef enum logic [1:0] {
      OP_IDLE,
      OP_STORE,
      OP_COMMIT,
      OP_BOTH     // store and commit on the same edge
   } op_e;

   typedef struct packed {
      op_e                              op;
      stbuf_pkg::store_size_e           size;
      logic [stbuf_pkg::ADDR_W-1:0]     addr;
      logic [stbuf_pkg::DATA_W-1:0]     data;
      logic [stbuf_pkg::WADDR_W-1:0]    ld_addr;
      stbuf_pkg::stbuf_drain_t          exp_drain;
      stbuf_pkg::ld_fwd_t               exp_fwd;
      logic                             exp_full;
      logic                             exp_empty;
   } row_t;

   logic                            clk = 1'b0;
   logic                            rst_n;
   stbuf_pkg::store_req_t           store;
   logic                            commit;
   logic [stbuf_pkg::WADDR_W-1:0]   ld_word_addr;
   stbuf_pkg::stbuf_drain_t         drain;
   stbuf_pkg::ld_fwd_t              fwd;
   logic                            full;
   logic                            empty;

   row_t                    rows [$];
   stbuf_pkg::stbuf_entry_t model_q [stbuf_pkg::DEPTH];   // reference entries
   int                      wr_idx;
   int                      rd_idx;
   int                      count;

   `include "stbuf_checks.svh"

   stbuf_top uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .store        (store),
      .commit       (commit),
      .ld_word_addr (ld_word_addr),
      .drain        (drain),
      .fwd          (fwd),
      .full         (full),
      .empty        (empty)
   );

   always #5 clk = ~clk;

   task automatic add_row(input op_e op, input stbuf_pkg::store_size_e size,
                          input logic [15:0] addr, input logic [31:0] data,
                          input logic [13:0] ld_addr);
      row_t r;
      r         = '0;
      r.op      = op;
      r.size    = size;
      r.addr    = addr;
      r.data    = data;
      r.ld_addr = ld_addr;
      rows.push_back(r);
   endtask

   // ------------------------------
   // stimulus table
   // ------------------------------
   task automatic build_table();
      // byte, half, word at different offsets, then drain in order
      add_row(OP_STORE,  stbuf_pkg::SZ_BYTE, 16'h0103, $urandom(), 14'h040);
      add_row(OP_STORE,  stbuf_pkg::SZ_HALF, 16'h0206, $urandom(), 14'h081);
      add_row(OP_STORE,  stbuf_pkg::SZ_WORD, 16'h0300, $urandom(), 14'h0c0);
      add_row(OP_COMMIT, stbuf_pkg::SZ_BYTE, 16'h0000, 32'h0,      14'h040);
      add_row(OP_COMMIT, stbuf_pkg::SZ_BYTE, 16'h0000, 32'h0,      14'h081);
      add_row(OP_COMMIT, stbuf_pkg::SZ_BYTE, 16'h0000, 32'h0,      14'h0c0);
      // coalescing into one word
      add_row(OP_STORE,  stbuf_pkg::SZ_HALF, 16'h0400, 32'h0000_1111, 14'h100);
      add_row(OP_STORE,  stbuf_pkg::SZ_BYTE, 16'h0401, 32'h0000_00ab, 14'h100);
      add_row(OP_STORE,  stbuf_pkg::SZ_HALF, 16'h0402, 32'h0000_2233, 14'h100);
      add_row(OP_STORE,  stbuf_pkg::SZ_WORD, 16'h0500, $urandom(),    14'h140);
      add_row(OP_BOTH,   stbuf_pkg::SZ_BYTE, 16'h0400, 32'h0000_00cd, 14'h100);
      add_row(OP_COMMIT, stbuf_pkg::SZ_BYTE, 16'h0000, 32'h0,         14'h100);
      add_row(OP_COMMIT, stbuf_pkg::SZ_BYTE, 16'h0000, 32'h0,         14'h100);
      // fill up, then store and commit together
      add_row(OP_STORE,  stbuf_pkg::SZ_WORD, 16'h0600, $urandom(), 14'h1c0);
      add_row(OP_STORE,  stbuf_pkg::SZ_WORD, 16'h0700, $urandom(), 14'h1c0);
      add_row(OP_STORE,  stbuf_pkg::SZ_WORD, 16'h0800, $urandom(), 14'h1c0);
      add_row(OP_STORE,  stbuf_pkg::SZ_WORD, 16'h0900, $urandom(), 14'h1c0);
      add_row(OP_COMMIT, stbuf_pkg::SZ_BYTE, 16'h0000, 32'h0,      14'h180);
      add_row(OP_BOTH,   stbuf_pkg::SZ_BYTE, 16'h0a02, $urandom(), 14'h280);
      add_row(OP_BOTH,   stbuf_pkg::SZ_HALF, 16'h0b00, $urandom(), 14'h2c0);
      add_row(OP_STORE,  stbuf_pkg::SZ_BYTE, 16'h0a00, $urandom(), 14'h280);
      add_row(OP_COMMIT, stbuf_pkg::SZ_BYTE, 16'h0000, 32'h0,      14'h280);
      add_row(OP_COMMIT, stbuf_pkg::SZ_BYTE, 16'h0000, 32'h0,      14'h280);
      add_row(OP_COMMIT, stbuf_pkg::SZ_BYTE, 16'h0000, 32'h0,      14'h280);
      add_row(OP_IDLE,   stbuf_pkg::SZ_BYTE, 16'h0000, 32'h0,      14'h280);
   endtask

   // ------------------------------
   // reference model
   // ------------------------------
   task automatic model_step(inout row_t r);
      logic [3:0]  be;
      logic [31:0] data;
      int          nbytes;
      int          ofs;
      int          hit;
      int          head;
      logic        st;
      logic        pop;
      be     = '0;
      data   = '0;
      nbytes = (r.size == stbuf_pkg::SZ_BYTE) ? 1 : (r.size == stbuf_pkg::SZ_HALF) ? 2 : 4;
      ofs    = int'(r.addr[1:0]);
      for (int k = 0; k < nbytes; k++) begin
         if (ofs + k < stbuf_pkg::BYTE_W) begin   // bytes past the word are lost
            be[ofs+k]             = 1'b1;
            data[8*(ofs+k) +: 8]  = r.data[8*k +: 8];
         end
      end
      st   = (r.op == OP_STORE) || (r.op == OP_BOTH);
      pop  = ((r.op == OP_COMMIT) || (r.op == OP_BOTH)) && model_q[rd_idx].valid;
      head = rd_idx;
      hit  = -1;
      for (int j = 0; j < stbuf_pkg::DEPTH; j++) begin
         if (st && model_q[j].valid && !(pop && j == head) &&
             model_q[j].waddr == r.addr[stbuf_pkg::ADDR_W-1:stbuf_pkg::OFS_W]) begin
            hit = j;
         end
      end
      if (hit >= 0) begin
         model_q[hit].be = model_q[hit].be | be;
         for (int b = 0; b < stbuf_pkg::BYTE_W; b++) begin
            if (be[b]) model_q[hit].data[8*b +: 8] = data[8*b +: 8];
         end
      end
      if (pop) begin
         model_q[head].valid = 1'b0;
         rd_idx = (rd_idx + 1) % stbuf_pkg::DEPTH;
         count--;
      end
      if (st && hit < 0) begin
         model_q[wr_idx].valid = 1'b1;
         model_q[wr_idx].waddr = r.addr[stbuf_pkg::ADDR_W-1:stbuf_pkg::OFS_W];
         model_q[wr_idx].be    = be;
         model_q[wr_idx].data  = data;
         wr_idx = (wr_idx + 1) % stbuf_pkg::DEPTH;
         count++;
      end
      r.exp_drain = model_q[rd_idx];
      r.exp_fwd   = '0;
      for (int j = 0; j < stbuf_pkg::DEPTH; j++) begin
         if (model_q[j].valid && model_q[j].waddr == r.ld_addr) begin
            r.exp_fwd.be = r.exp_fwd.be | model_q[j].be;
            for (int b = 0; b < stbuf_pkg::BYTE_W; b++) begin
               if (model_q[j].be[b]) r.exp_fwd.data[8*b +: 8] = model_q[j].data[8*b +: 8];
            end
         end
      end
      r.exp_full  = (count == stbuf_pkg::DEPTH);
      r.exp_empty = (count == 0);
   endtask

   // fill in the expected columns row by row
   task automatic predict_table();
      row_t r;
      for (int j = 0; j < stbuf_pkg::DEPTH; j++) model_q[j] = '0;
      wr_idx = 0;
      rd_idx = 0;
      count  = 0;
      for (int i = 0; i < rows.size(); i++) begin
         r = rows[i];
         model_step(r);
         rows[i] = r;
      end
   endtask

   initial begin : watchdog
      #1;
      #((rows.size() + 10) * 10 + 100);
      abort_run("timeout: the stimulus table did not complete");
   end

   initial begin
      row_t r;
      void'($urandom(89614));
      rst_n        = 1'b0;
      store        = '0;
      commit       = 1'b0;
      ld_word_addr = '0;
      build_table();
      predict_table();
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_flag("empty", empty, 1'b1);
      check_flag("full", full, 1'b0);
      check_flag("drain.valid", drain.valid, 1'b0);
      for (int i = 0; i < rows.size(); i++) begin
         r            = rows[i];
         store.valid  = (r.op == OP_STORE) || (r.op == OP_BOTH);
         store.size   = r.size;
         store.addr   = r.addr;
         store.data   = r.data;
         commit       = (r.op == OP_COMMIT) || (r.op == OP_BOTH);
         ld_word_addr = r.ld_addr;
         @(negedge clk);   // one edge later
         check_drain("drain", drain, r.exp_drain);
         check_fwd("fwd", fwd, r.exp_fwd);
         check_flag("full", full, r.exp_full);
         check_flag("empty", empty, r.exp_empty);
      end
      $display("Verification passed");
      $finish;
   end

endmodule
